// ==== logic/ctr_macros.svh ====
// Counter engine constants
// Slice geometry and credit depth of the slice-serial counter

`ifndef CTR_MACROS_SVH
`define CTR_MACROS_SVH

// One counter slice, a 16-bit word
`define CTR_SLICE_W 16

// Slices per counter, must be a power of two
`define CTR_NUM_SLICES 8

// Full counter width
`define CTR_WIDTH (`CTR_SLICE_W * `CTR_NUM_SLICES)

// Credits after reset, also the pending queue depth
`define CTR_CREDITS 2

`endif

// ==== logic/ctr_data_pkg.sv ====
// Counter engine data types
// Vector typedefs for slices, indices, full values and credit counts

`include "ctr_macros.svh"

package ctr_data_pkg;

  // One slice of the counter
  typedef logic [`CTR_SLICE_W-1:0] ctr_slice_t;

  // Slice index, log2 of the slice count
  typedef logic [$clog2(`CTR_NUM_SLICES)-1:0] ctr_idx_t;

  // Whole 128-bit counter
  typedef logic [`CTR_WIDTH-1:0] ctr_value_t;

  // Pending queue count
  // Holds 0 up to CTR_CREDITS
  typedef logic [$clog2(`CTR_CREDITS+1)-1:0] ctr_credit_t;

endpackage

// ==== logic/ctr_ctrl_pkg.sv ====
// Counter engine control encodings
// Sparse FSM state codes and sparse increment command

package ctr_ctrl_pkg;

  // FSM state, 6-bit sparse codes
  // Pairwise Hamming distance is 3 or more
  //   IDLE  vs INCR  : 5
  //   IDLE  vs ERROR : 4
  //   INCR  vs ERROR : 3
  typedef enum logic [5:0] {
    CTR_IDLE  = 6'b011100,
    CTR_INCR  = 6'b101011,
    CTR_ERROR = 6'b110001
  } ctr_state_e;

  // Increment command vector
  typedef logic [3:0] ctr_cmd_t;

  // Only valid increment code
  // Anything else with a valid strobe is a multi-rail error
  parameter ctr_cmd_t CTR_CMD_INCR = 4'b1010;

endpackage

// ==== logic/ctr_req_gate.sv ====
// Counter command intake
// Decodes the sparse command, queues pending increments under credit
// flow control, returns credits and raises sticky error flags

`timescale 1ns/1ps

`include "ctr_macros.svh"

module ctr_req_gate import ctr_data_pkg::*, ctr_ctrl_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     cmd_valid_i,
  input  ctr_cmd_t cmd_i,
  input  logic     ready_i,
  input  logic     done_i,
  output logic     incr_o,
  output logic     incr_err_o,
  output logic     mr_err_o,
  output logic     credit_o
);

  ctr_credit_t count_d, count_q;
  logic        cmd_ok;
  logic        full;
  logic        push;
  logic        pop;
  logic        incr_err_q, mr_err_q;

  //////////////////////////////////////////////////
  // Command decode and queue count
  //////////////////////////////////////////////////

  // Exact match against the sparse code
  assign cmd_ok = (cmd_i == CTR_CMD_INCR);
  assign full   = (count_q == ctr_credit_t'(`CTR_CREDITS));

  // Only good commands into a non-full queue
  assign push = cmd_valid_i && cmd_ok && !full;
  // Increment taken by the FSM
  assign pop  = incr_o && ready_i;

  always_comb begin
    count_d = count_q;
    case ({push, pop})
      2'b10:   count_d = count_q + ctr_credit_t'(1);
      2'b01:   count_d = count_q - ctr_credit_t'(1);
      // Push and pop together leave the count as is
      default: count_d = count_q;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q    <= '0;
      incr_err_q <= 1'b0;
      mr_err_q   <= 1'b0;
    end else begin
      count_q <= count_d;
      // Sticky overflow, command hit a full queue
      if (cmd_valid_i && full) begin
        incr_err_q <= 1'b1;
      end
      // Sticky multi-rail error on a bad code
      if (cmd_valid_i && !cmd_ok) begin
        mr_err_q <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////

  assign incr_o     = (count_q != '0);
  assign incr_err_o = incr_err_q;
  assign mr_err_o   = mr_err_q;
  // One credit back per finished increment
  assign credit_o   = done_i;

  // Credits only come back from a running increment
  credit_busy_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |-> !ready_i);

endmodule

// ==== logic/ctr_fsm.sv ====
// Slice-serial counter increment FSM
// Walks the slices from LSB to MSB, adding the carry to one slice per
// cycle, and locks into a terminal error state on any fault

`timescale 1ns/1ps

`include "ctr_macros.svh"

module ctr_fsm import ctr_data_pkg::*, ctr_ctrl_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  input  logic       incr_i,
  output logic       ready_o,
  input  logic       incr_err_i,
  input  logic       mr_err_i,
  output logic       alert_o,
  output logic       done_o,

  output ctr_idx_t   slice_idx_o,
  input  ctr_slice_t slice_i,
  output ctr_slice_t slice_o,
  output logic       slice_we_o
);

  ctr_state_e                state_d, state_q;
  ctr_idx_t                  idx_d, idx_q;
  logic                      carry_d, carry_q;
  logic                      err;
  logic                      last;
  logic [`CTR_SLICE_W:0]     sum;

  //////////////////////////////////////////////////
  // Slice adder
  //////////////////////////////////////////////////

  // Read slice plus carry, top bit is the carry out
  assign sum     = {1'b0, slice_i} + (`CTR_SLICE_W+1)'(carry_q);
  assign slice_o = sum[`CTR_SLICE_W-1:0];

  assign err  = incr_err_i || mr_err_i;
  assign last = (idx_q == ctr_idx_t'(`CTR_NUM_SLICES - 1));

  //////////////////////////////////////////////////
  // Next state and outputs
  //////////////////////////////////////////////////

  always_comb begin
    // Defaults
    ready_o    = 1'b0;
    slice_we_o = 1'b0;
    done_o     = 1'b0;
    alert_o    = 1'b0;
    state_d    = state_q;
    idx_d      = idx_q;
    carry_d    = carry_q;

    case (state_q)
      CTR_IDLE: begin
        ready_o = 1'b1;
        if (incr_i) begin
          // Start at slice 0, increment by one
          idx_d   = '0;
          carry_d = 1'b1;
          state_d = CTR_INCR;
        end
      end

      CTR_INCR: begin
        idx_d      = idx_q + ctr_idx_t'(1);
        carry_d    = sum[`CTR_SLICE_W];
        slice_we_o = 1'b1;
        done_o     = last;
        if (last) begin
          state_d = CTR_IDLE;
        end
      end

      CTR_ERROR: begin
        // Terminal, only reset leaves
        alert_o = 1'b1;
      end

      default: begin
        // Corrupted state code
        alert_o = 1'b1;
        state_d = CTR_ERROR;
      end
    endcase

    // Any flagged error forces the terminal state
    // No write or credit once a flag is up
    if (err) begin
      state_d    = CTR_ERROR;
      slice_we_o = 1'b0;
      done_o     = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= CTR_IDLE;
      idx_q   <= '0;
      carry_q <= 1'b0;
    end else begin
      state_q <= state_d;
      idx_q   <= idx_d;
      carry_q <= carry_d;
    end
  end

  assign slice_idx_o = idx_q;

  // Without a flagged error the FSM sits in a working state
  state_valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !err |-> state_q inside {CTR_IDLE, CTR_INCR});

endmodule

// ==== logic/ctr_reg.sv ====
// Counter storage
// Slice registers loaded whole from outside or written one slice
// at a time by the increment FSM

`timescale 1ns/1ps

`include "ctr_macros.svh"

module ctr_reg import ctr_data_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       load_i,
  input  ctr_value_t load_value_i,
  input  logic       idle_i,
  input  ctr_idx_t   slice_idx_i,
  input  logic       slice_we_i,
  input  ctr_slice_t slice_wdata_i,
  output ctr_slice_t slice_rdata_o,
  output ctr_value_t value_o
);

  ctr_slice_t slices_q [`CTR_NUM_SLICES];

  //////////////////////////////////////////////////
  // Slice array
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `CTR_NUM_SLICES; i++) begin
        slices_q[i] <= '0;
      end
    end else if (load_i) begin
      // Whole counter in one cycle
      for (int i = 0; i < `CTR_NUM_SLICES; i++) begin
        slices_q[i] <= load_value_i[i*`CTR_SLICE_W +: `CTR_SLICE_W];
      end
    end else if (slice_we_i) begin
      slices_q[slice_idx_i] <= slice_wdata_i;
    end
  end

  // Selected slice back to the FSM adder
  assign slice_rdata_o = slices_q[slice_idx_i];

  // Flatten, slice 0 is the LSB
  always_comb begin
    for (int i = 0; i < `CTR_NUM_SLICES; i++) begin
      value_o[i*`CTR_SLICE_W +: `CTR_SLICE_W] = slices_q[i];
    end
  end

  // Loads only land on an idle engine
  load_idle_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    load_i |-> idle_i);

  // Load never races a slice write
  load_we_excl_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(load_i && slice_we_i));

endmodule

// ==== logic/ctr_top.sv ====
// Counter engine top level
// Command gate, slice-serial FSM and counter storage

`timescale 1ns/1ps

module ctr_top import ctr_data_pkg::*, ctr_ctrl_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       cmd_valid_i,
  input  ctr_cmd_t   cmd_i,
  input  logic       load_i,
  input  ctr_value_t load_value_i,
  output logic       credit_o,
  output logic       alert_o,
  output logic       idle_o,
  output ctr_value_t ctr_value_o
);

  // Gate to FSM
  logic       incr, ready, done;
  logic       incr_err, mr_err;
  // FSM to storage
  ctr_idx_t   slice_idx;
  ctr_slice_t slice_wdata, slice_rdata;
  logic       slice_we;

  ctr_req_gate i_gate (
    .clk_i,
    .rst_ni,
    .cmd_valid_i,
    .cmd_i,
    .ready_i    (ready),
    .done_i     (done),
    .incr_o     (incr),
    .incr_err_o (incr_err),
    .mr_err_o   (mr_err),
    .credit_o
  );

  ctr_fsm i_fsm (
    .clk_i,
    .rst_ni,
    .incr_i      (incr),
    .ready_o     (ready),
    .incr_err_i  (incr_err),
    .mr_err_i    (mr_err),
    .alert_o,
    .done_o      (done),
    .slice_idx_o (slice_idx),
    .slice_i     (slice_rdata),
    .slice_o     (slice_wdata),
    .slice_we_o  (slice_we)
  );

  ctr_reg i_reg (
    .clk_i,
    .rst_ni,
    .load_i,
    .load_value_i,
    .idle_i        (ready),
    .slice_idx_i   (slice_idx),
    .slice_we_i    (slice_we),
    .slice_wdata_i (slice_wdata),
    .slice_rdata_o (slice_rdata),
    .value_o       (ctr_value_o)
  );

  // Idle is the FSM ready
  assign idle_o = ready;

endmodule

// ==== bench/ctr_top_tb.sv ====
// Counter engine testbench
// Replays the cases file on the counter top level and checks the
// counter value, the credit returns and the sticky alert

`timescale 1ns/1ps

`include "ctr_macros.svh"

module ctr_top_tb import ctr_data_pkg::*, ctr_ctrl_pkg::*; ();

  localparam int wait_limit   = 64;
  localparam int quiet_cycles = 24;

  logic        clk;
  logic        rst_n;
  logic        cmd_valid;
  ctr_cmd_t    cmd;
  logic        load;
  ctr_value_t  load_value;
  logic        credit;
  logic        alert;
  logic        idle;
  ctr_value_t  ctr_value;

  // Upstream credit model and bookkeeping
  int          credits;
  int          pulses;
  int          errors;
  int          case_no;
  int          pass_cnt;
  int          fail_cnt;
  int          fd;
  int          status;
  int unsigned seed;
  string       op;
  ctr_value_t  operand;
  ctr_value_t  expected;
  logic [8*256-1:0] rest;

  ctr_top i_dut (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .cmd_valid_i  (cmd_valid),
    .cmd_i        (cmd),
    .load_i       (load),
    .load_value_i (load_value),
    .credit_o     (credit),
    .alert_o      (alert),
    .idle_o       (idle),
    .ctr_value_o  (ctr_value)
  );

  // 40 ns clock
  always #20 clk = ~clk;

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  // One cycle, inputs set at the rising edge, credit sampled mid-cycle
  task automatic step(input logic valid, input ctr_cmd_t code);
    @(posedge clk);
    cmd_valid <= valid;
    cmd       <= code;
    load      <= 1'b0;
    @(negedge clk);
    if (credit) begin
      credits++;
      pulses++;
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n     <= 1'b0;
    cmd_valid <= 1'b0;
    load      <= 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    credits = `CTR_CREDITS;
  endtask

  // Whole counter load, visible at the following negedge
  task automatic load_counter(input ctr_value_t value);
    @(posedge clk);
    load       <= 1'b1;
    load_value <= value;
    cmd_valid  <= 1'b0;
    step(1'b0, '0);
  endtask

  // Sends only while a credit is held, back to back when possible
  task automatic issue_incrs(input int count);
    int left;
    int n;
    left = count;
    n    = 0;
    while (left > 0 && n < wait_limit) begin
      if (credits > 0) begin
        credits--;
        left--;
        step(1'b1, CTR_CMD_INCR);
      end else begin
        step(1'b0, '0);
      end
      n++;
    end
    if (left > 0) begin
      $display("Timeout: no credit to send %0d more increments in %0d cycles", left, wait_limit);
      errors++;
    end
  endtask

  // All credits back and the engine idle
  task automatic settle();
    int n;
    n = 0;
    while ((credits < `CTR_CREDITS || !idle) && n < wait_limit) begin
      step(1'b0, '0);
      n++;
    end
    if (credits < `CTR_CREDITS || !idle) begin
      $display("Timeout: credits and idle not restored within %0d cycles", wait_limit);
      errors++;
    end
  endtask

  task automatic wait_alert();
    int n;
    n = 0;
    while (!alert && n < wait_limit) begin
      step(1'b0, '0);
      n++;
    end
    if (!alert) begin
      $display("Timeout: alert_o did not rise within %0d cycles", wait_limit);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic check_value(input ctr_value_t exp_value);
    if (ctr_value !== exp_value) begin
      $display("MISMATCH ctr_value_o: got 0x%h expected 0x%h", ctr_value, exp_value);
      errors++;
    end
  endtask

  task automatic check_reset_state();
    if (alert !== 1'b0) begin
      $display("MISMATCH alert_o: got 0x%h expected 0x0", alert);
      errors++;
    end
    if (idle !== 1'b1) begin
      $display("MISMATCH idle_o: got 0x%h expected 0x1", idle);
      errors++;
    end
    check_value('0);
  endtask

  //////////////////////////////////////////////////
  // Case kinds
  //////////////////////////////////////////////////

  task automatic run_incr(input int count, input ctr_value_t exp_value);
    int start;
    start = pulses;
    issue_incrs(count);
    settle();
    if (pulses - start != count) begin
      $display("MISMATCH credit_o pulses: got 0x%0h expected 0x%0h", pulses - start, count);
      errors++;
    end
    check_value(exp_value);
  endtask

  task automatic run_random(input int rounds);
    ctr_value_t value;
    int         count;
    for (int r = 0; r < rounds; r++) begin
      value = {$urandom, $urandom, $urandom, $urandom};
      // Ones in the low slices on some rounds for long carry chains
      if ($urandom % 2) begin
        value[47:0] = '1;
      end
      count = 1 + int'($urandom % 3);
      settle();
      load_counter(value);
      issue_incrs(count);
      settle();
      check_value(value + ctr_value_t'(count));
    end
  endtask

  // Bad code locks the engine, counter must hold its value
  task automatic run_bad_cmd(input ctr_cmd_t code, input ctr_value_t exp_value);
    int start;
    int drops;
    settle();
    start = pulses;
    drops = 0;
    credits--;
    step(1'b1, code);
    wait_alert();
    for (int n = 0; n < quiet_cycles; n++) begin
      step(1'b0, '0);
      if (!alert) begin
        drops++;
      end
    end
    if (drops != 0) begin
      $display("alert_o fell in %0d cycles after the bad command", drops);
      errors++;
    end
    if (pulses != start) begin
      $display("A credit came back after the bad command");
      errors++;
    end
    check_value(exp_value);
    apply_reset();
    check_reset_state();
  endtask

  // First command is taken at once, so one extra is needed to overflow
  task automatic run_flood(input int count);
    settle();
    for (int n = 0; n < count; n++) begin
      step(1'b1, CTR_CMD_INCR);
    end
    wait_alert();
    apply_reset();
    check_reset_state();
  endtask

  task automatic report_case(input string name);
    case_no++;
    if (errors == 0) begin
      pass_cnt++;
      $display("Case %0d %s: pass", case_no, name);
    end else begin
      fail_cnt++;
      $display("Case %0d %s: fail with %0d errors", case_no, name, errors);
    end
  endtask

  task automatic run_case(input string name, input ctr_value_t arg, input ctr_value_t exp_value);
    errors = 0;
    if (name == "LOAD") begin
      settle();
      load_counter(arg);
      check_value(exp_value);
    end else if (name == "INCR") begin
      run_incr(int'(arg), exp_value);
    end else if (name == "RAND") begin
      run_random(int'(arg));
    end else if (name == "BADCMD") begin
      run_bad_cmd(ctr_cmd_t'(arg), exp_value);
    end else if (name == "FLOOD") begin
      run_flood(int'(arg));
    end else begin
      $display("Unknown operation %s in the cases file", name);
      errors++;
    end
    report_case(name);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    cmd_valid  = 1'b0;
    cmd        = '0;
    load       = 1'b0;
    load_value = '0;
    credits    = `CTR_CREDITS;
    pulses     = 0;
    case_no    = 0;
    pass_cnt   = 0;
    fail_cnt   = 0;
    seed       = 32'h04c5_2468;
    status     = $urandom(seed);

    apply_reset();
    errors = 0;
    check_reset_state();
    report_case("RESET");

    fd = $fopen("bench/ctr_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the cases file bench/ctr_cases.txt");
      fail_cnt++;
    end else begin
      while (!$feof(fd)) begin
        if ($fscanf(fd, "%s", op) == 1) begin
          // Comment lines start with a hash
          if (op.substr(0, 0) == "#") begin
            status = $fgets(rest, fd);
          end else if ($fscanf(fd, "%h %h", operand, expected) == 2) begin
            run_case(op, operand, expected);
          end else begin
            $display("Malformed line for operation %s in the cases file", op);
            fail_cnt++;
          end
        end
      end
      $fclose(fd);
    end

    $display("Cases passed: %0d, cases failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+logic
logic/ctr_data_pkg.sv
logic/ctr_ctrl_pkg.sv
logic/ctr_req_gate.sv
logic/ctr_fsm.sv
logic/ctr_reg.sv
logic/ctr_top.sv
bench/ctr_top_tb.sv

// ==== Bender.yml ====
package:
  name: ctr_engine

export_include_dirs:
  - logic

sources:
  - target: rtl
    files:
      - logic/ctr_data_pkg.sv
      - logic/ctr_ctrl_pkg.sv
      - logic/ctr_req_gate.sv
      - logic/ctr_fsm.sv
      - logic/ctr_reg.sv
      - logic/ctr_top.sv
  - target: bench
    files:
      - bench/ctr_top_tb.sv

// ==== bench/ctr_cases.txt ====
# op     operand (hex, 128 bit)             expected counter after the case (hex, 128 bit)
# INCR operand is the increment count, BADCMD the bad code, FLOOD the command count, RAND rounds
INCR   1                                  00000000000000000000000000000001
LOAD   0123456789abcdef0011223344556677   0123456789abcdef0011223344556677
INCR   1                                  0123456789abcdef0011223344556678
LOAD   0000000000000000000000000000ffff   0000000000000000000000000000ffff
INCR   1                                  00000000000000000000000000010000
LOAD   00000000000000000000ffffffffffff   00000000000000000000ffffffffffff
INCR   1                                  00000000000000000001000000000000
LOAD   0000ffff0000ffff0000ffff0000ffff   0000ffff0000ffff0000ffff0000ffff
INCR   1                                  0000ffff0000ffff0000ffff00010000
LOAD   7fffffffffffffffffffffffffffffff   7fffffffffffffffffffffffffffffff
INCR   1                                  80000000000000000000000000000000
LOAD   ffffffffffffffffffffffffffffffff   ffffffffffffffffffffffffffffffff
INCR   1                                  00000000000000000000000000000000
LOAD   0000000000000000000000000000fffe   0000000000000000000000000000fffe
INCR   2                                  00000000000000000000000000010000
RAND   a                                  00000000000000000000000000000000
LOAD   00000000deadbeef00000000cafef00d   00000000deadbeef00000000cafef00d
BADCMD 5                                  00000000deadbeef00000000cafef00d
FLOOD  4                                  00000000000000000000000000000000
INCR   1                                  00000000000000000000000000000001
